/* src/iq_geom_pkg.sv */
//**************************************************************************
// Geometry defaults of the two-thread instruction queue. The top level takes
// these as its parameter defaults and passes the values down to its blocks.
//**************************************************************************

`default_nettype none

package iq_geom_pkg;

  // entries held per thread; the pointer logic relies on a power of two.
  localparam int IQ_DEPTH = 16;

  // entries that fetch can push in one cycle.
  localparam int IQ_WR_LANES = 4;

  // head entries presented to decode in one cycle.
  localparam int IQ_RD_LANES = 4;

  // Thread selects are single bits, so only two threads are supported.
  localparam int IQ_THREADS = 2;

endpackage : iq_geom_pkg

`default_nettype wire

/* src/iq_entry_pkg.sv */
//**************************************************************************
// Layout of one queue entry as it travels from fetch through the queue to
// decode. It is imported by the datapath blocks and by the testbench.
//**************************************************************************

`default_nettype none

package iq_entry_pkg;

  // width of the raw instruction word.
  localparam int IQ_INSTR_W = 32;

  // width of the predecode side-band that rides along with each word.
  localparam int IQ_OTHER_W = 8;

  // The instruction sits in the upper bits and the tag sits in the low byte.
  typedef struct packed {
    logic [IQ_INSTR_W-1:0] instr;
    logic [IQ_OTHER_W-1:0] other;
  } iq_entry_t;

endpackage : iq_entry_pkg

`default_nettype wire

/* src/iq_ctrl.sv */
//**************************************************************************
// Queue control. Keeps the head, tail and occupancy of both threads, drives
// the fetch stall and the read-available flags, and applies the flush.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module iq_ctrl
  import iq_geom_pkg::*;
#(
  parameter int DEPTH    = IQ_DEPTH,
  parameter int WR_LANES = IQ_WR_LANES,
  parameter int RD_LANES = IQ_RD_LANES
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr_valid,
  input  logic                          wr_thread,
  input  logic [WR_LANES-1:0]           wr_mask,
  input  logic                          rd_thread,
  input  logic [RD_LANES-1:0]           rd_take,
  input  logic                          flush,
  input  logic                          flush_thread,
  output logic                          wr_stall,
  output logic                          wr_accept,
  output logic [$clog2(WR_LANES+1)-1:0] wr_cnt,
  output logic [$clog2(DEPTH)-1:0]      wr_tail,
  output logic [$clog2(DEPTH)-1:0]      rd_head,
  output logic [RD_LANES-1:0]           rd_avail
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int OCC_W = $clog2(DEPTH + 1);
  localparam int WC_W  = $clog2(WR_LANES + 1);
  localparam int RC_W  = $clog2(RD_LANES + 1);

  // a full write group must still fit, so stall above this level.
  localparam logic [OCC_W-1:0] STALL_LVL = OCC_W'(DEPTH - WR_LANES);

  logic [PTR_W-1:0] head [IQ_THREADS];
  logic [PTR_W-1:0] tail [IQ_THREADS];
  logic [OCC_W-1:0] occ  [IQ_THREADS];

  logic [OCC_W-1:0]      wr_occ;
  logic [OCC_W-1:0]      rd_occ;
  logic [RC_W-1:0]       rd_cnt;
  logic [IQ_THREADS-1:0] fl_hit;
  logic [IQ_THREADS-1:0] wr_hit;
  logic [IQ_THREADS-1:0] rd_hit;

  // Counts the run of ones starting at bit 0; anything past the first zero
  // is ignored, which is how both lane masks are defined.
  function automatic int unsigned lead_ones(input logic [31:0] m);
    int unsigned n;
    logic        run;
    n   = 0;
    run = 1'b1;
    for (int i = 0; i < 32; i++) begin
      run = run & m[i];
      n   = n + run;
    end
    return n;
  endfunction

  assign wr_occ = occ[wr_thread];
  assign rd_occ = occ[rd_thread];

  assign wr_stall  = wr_occ > STALL_LVL; // independent of wr_valid.
  assign wr_accept = wr_valid & ~wr_stall;
  assign wr_cnt    = WC_W'(lead_ones(32'(wr_mask)));
  assign wr_tail   = tail[wr_thread];
  assign rd_head   = head[rd_thread];

  always_comb begin
    for (int r = 0; r < RD_LANES; r++) begin
      rd_avail[r] = rd_occ > OCC_W'(r);
    end
  end

  // rd_avail is a thermometer code, so masking the take with it clips the
  // pop count to the occupancy.
  assign rd_cnt = RC_W'(lead_ones(32'(rd_take & rd_avail)));

  always_comb begin
    for (int t = 0; t < IQ_THREADS; t++) begin
      fl_hit[t] = flush && (int'(flush_thread) == t);
      wr_hit[t] = wr_accept && (int'(wr_thread) == t);
      rd_hit[t] = int'(rd_thread) == t;
    end
  end

  always_ff @(posedge clk) begin
    for (int t = 0; t < IQ_THREADS; t++) begin
      if (rst || fl_hit[t]) begin // flush beats a write or pop to the same thread.
        head[t] <= '0;
        tail[t] <= '0;
        occ[t]  <= '0;
      end else begin
        if (wr_hit[t]) begin
          tail[t] <= tail[t] + PTR_W'(wr_cnt); // wraps modulo DEPTH.
        end
        if (rd_hit[t]) begin
          head[t] <= head[t] + PTR_W'(rd_cnt);
        end
        occ[t] <= occ[t] + (wr_hit[t] ? OCC_W'(wr_cnt) : '0)
                         - (rd_hit[t] ? OCC_W'(rd_cnt) : '0);
      end
    end
  end

endmodule : iq_ctrl

`default_nettype wire

/* src/iq_store.sv */
//**************************************************************************
// Entry storage for both threads. Write lanes land at consecutive slots from
// the tail; read lanes return entries combinationally.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module iq_store
  import iq_geom_pkg::*;
  import iq_entry_pkg::*;
#(
  parameter int DEPTH    = IQ_DEPTH,
  parameter int WR_LANES = IQ_WR_LANES,
  parameter int RD_LANES = IQ_RD_LANES
) (
  input  logic                                  clk,
  input  logic                                  wr_accept,
  input  logic                                  wr_thread,
  input  logic [$clog2(DEPTH)-1:0]              wr_tail,
  input  logic [$clog2(WR_LANES+1)-1:0]         wr_cnt,
  input  iq_entry_t [WR_LANES-1:0]              wr_data,
  input  logic                                  rd_thread,
  input  logic [RD_LANES-1:0][$clog2(DEPTH)-1:0] rd_addr,
  output iq_entry_t [RD_LANES-1:0]              rd_entry
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int WC_W  = $clog2(WR_LANES + 1);

  iq_entry_t mem [IQ_THREADS][DEPTH];

  logic [WR_LANES-1:0][PTR_W-1:0] wr_addr;
  logic [WR_LANES-1:0]            wr_en;

  // Lane w lands w slots past the tail. Lanes at or above the count are
  // held off so a short group leaves the rest of the thread untouched.
  always_comb begin
    for (int w = 0; w < WR_LANES; w++) begin
      wr_addr[w] = wr_tail + PTR_W'(w);
      wr_en[w]   = wr_accept && (WC_W'(w) < wr_cnt);
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < WR_LANES; w++) begin
      if (wr_en[w]) begin
        mem[wr_thread][wr_addr[w]] <= wr_data[w];
      end
    end
  end

  // Unwritten slots may hold anything; the read port hides them.
  always_comb begin
    for (int r = 0; r < RD_LANES; r++) begin
      rd_entry[r] = mem[rd_thread][rd_addr[r]];
    end
  end

endmodule : iq_store

`default_nettype wire

/* src/iq_read_port.sv */
//**************************************************************************
// Read-side address and data shaping. Forms one address per read lane from
// the head and forces lanes that hold no valid entry to zero.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module iq_read_port
  import iq_geom_pkg::*;
  import iq_entry_pkg::*;
#(
  parameter int DEPTH    = IQ_DEPTH,
  parameter int RD_LANES = IQ_RD_LANES
) (
  input  logic [$clog2(DEPTH)-1:0]               rd_head,
  input  logic [RD_LANES-1:0]                    rd_avail,
  input  iq_entry_t [RD_LANES-1:0]               rd_entry,
  output logic [RD_LANES-1:0][$clog2(DEPTH)-1:0] rd_addr,
  output iq_entry_t [RD_LANES-1:0]               rd_data
);

  localparam int PTR_W = $clog2(DEPTH);

  always_comb begin
    for (int r = 0; r < RD_LANES; r++) begin
      rd_addr[r] = rd_head + PTR_W'(r); // wraps modulo DEPTH.
    end
  end

  // Storage is never cleared, so stale slots past the occupancy must not
  // reach decode.
  always_comb begin
    for (int r = 0; r < RD_LANES; r++) begin
      rd_data[r] = rd_avail[r] ? rd_entry[r] : '0;
    end
  end

endmodule : iq_read_port

`default_nettype wire

/* src/instr_queue.sv */
//**************************************************************************
// Two-thread multi-lane instruction queue between fetch and decode. Fetch
// pushes up to WR_LANES entries per cycle; decode sees up to RD_LANES.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module instr_queue
  import iq_geom_pkg::*;
  import iq_entry_pkg::*;
#(
  parameter int DEPTH    = IQ_DEPTH,
  parameter int WR_LANES = IQ_WR_LANES,
  parameter int RD_LANES = IQ_RD_LANES
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     wr_valid,
  input  logic                     wr_thread,
  input  logic [WR_LANES-1:0]      wr_mask,
  input  iq_entry_t [WR_LANES-1:0] wr_data,
  input  logic                     rd_thread,
  input  logic [RD_LANES-1:0]      rd_take,
  input  logic                     flush,
  input  logic                     flush_thread,
  output logic                     wr_stall,
  output logic [RD_LANES-1:0]      rd_avail,
  output iq_entry_t [RD_LANES-1:0] rd_data
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int WC_W  = $clog2(WR_LANES + 1);

  logic                           wr_accept;
  logic [WC_W-1:0]                wr_cnt;
  logic [PTR_W-1:0]               wr_tail;
  logic [PTR_W-1:0]               rd_head;
  logic [RD_LANES-1:0][PTR_W-1:0] rd_addr;
  iq_entry_t [RD_LANES-1:0]       rd_entry;

  iq_ctrl #(
    .DEPTH   (DEPTH),
    .WR_LANES(WR_LANES),
    .RD_LANES(RD_LANES)
  ) ctrl0 (
    .clk         (clk),
    .rst         (rst),
    .wr_valid    (wr_valid),
    .wr_thread   (wr_thread),
    .wr_mask     (wr_mask),
    .rd_thread   (rd_thread),
    .rd_take     (rd_take),
    .flush       (flush),
    .flush_thread(flush_thread),
    .wr_stall    (wr_stall),
    .wr_accept   (wr_accept),
    .wr_cnt      (wr_cnt),
    .wr_tail     (wr_tail),
    .rd_head     (rd_head),
    .rd_avail    (rd_avail)
  );

  iq_store #(
    .DEPTH   (DEPTH),
    .WR_LANES(WR_LANES),
    .RD_LANES(RD_LANES)
  ) store0 (
    .clk      (clk),
    .wr_accept(wr_accept),
    .wr_thread(wr_thread),
    .wr_tail  (wr_tail),
    .wr_cnt   (wr_cnt),
    .wr_data  (wr_data),
    .rd_thread(rd_thread),
    .rd_addr  (rd_addr),
    .rd_entry (rd_entry)
  );

  iq_read_port #(
    .DEPTH   (DEPTH),
    .RD_LANES(RD_LANES)
  ) rport0 (
    .rd_head (rd_head),
    .rd_avail(rd_avail),
    .rd_entry(rd_entry),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule : instr_queue

`default_nettype wire

/* bench/iq_chk.sv */
//**************************************************************************
// Concurrent assertions on the queue control block, attached to every
// iq_ctrl instance by the bind at the bottom of this file.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module iq_chk
  import iq_geom_pkg::*;
#(
  parameter int DEPTH    = IQ_DEPTH,
  parameter int RD_LANES = IQ_RD_LANES
) (
  input logic                       clk,
  input logic                       rst,
  input logic                       wr_stall,
  input logic [$clog2(DEPTH+1)-1:0] occ0,
  input logic [$clog2(DEPTH+1)-1:0] occ1,
  input logic [RD_LANES-1:0]        rd_avail
);

  int fail_cnt = 0; // read by the testbench at the end of the run.

  logic [RD_LANES-1:0] avail_next;

  assign avail_next = rd_avail + 1'b1; // a thermometer code shares no bit with this.

  stall_after_reset: assert property (@(posedge clk) rst |=> !wr_stall)
    else begin
      $error("wr_stall is high in the cycle after reset");
      fail_cnt++;
    end

  occ_in_range: assert property (@(posedge clk) disable iff (rst)
    (occ0 <= DEPTH) && (occ1 <= DEPTH))
    else begin
      $error("thread occupancy exceeds the queue depth");
      fail_cnt++;
    end

  avail_thermo: assert property (@(posedge clk) disable iff (rst)
    (avail_next & rd_avail) == '0)
    else begin
      $error("rd_avail is not a thermometer code");
      fail_cnt++;
    end

endmodule : iq_chk

bind iq_ctrl iq_chk #(
  .DEPTH   (DEPTH),
  .RD_LANES(RD_LANES)
) chk0 (
  .clk     (clk),
  .rst     (rst),
  .wr_stall(wr_stall),
  .occ0    (occ[0]),
  .occ1    (occ[1]),
  .rd_avail(rd_avail)
);

`default_nettype wire

/* bench/instr_queue_tb.sv */
//**************************************************************************
// Self-checking testbench for the instruction queue. A stimulus table is
// applied row by row while a reference model predicts every output.
//**************************************************************************

`timescale 1ns/1ps
`default_nettype none

module instr_queue_tb
  import iq_geom_pkg::*;
  import iq_entry_pkg::*;
();

  localparam int DEPTH     = IQ_DEPTH;
  localparam int WR_LANES  = IQ_WR_LANES;
  localparam int RD_LANES  = IQ_RD_LANES;
  localparam int NSTEPS    = 32;
  localparam int IDLE_WAIT = 8;

  // one row of the stimulus table.
  typedef struct packed {
    logic                wr_valid;
    logic                wr_thread;
    logic [WR_LANES-1:0] wr_mask;
    logic                rd_thread;
    logic [RD_LANES-1:0] rd_take;
    logic                flush;
    logic                flush_thread;
  } step_t;

  logic                     clk;
  logic                     rst;
  logic                     wr_valid;
  logic                     wr_thread;
  logic [WR_LANES-1:0]      wr_mask;
  iq_entry_t [WR_LANES-1:0] wr_data;
  logic                     rd_thread;
  logic [RD_LANES-1:0]      rd_take;
  logic                     flush;
  logic                     flush_thread;
  logic                     wr_stall;
  logic [RD_LANES-1:0]      rd_avail;
  iq_entry_t [RD_LANES-1:0] rd_data;

  iq_entry_t mq [2][DEPTH]; // model queues with the oldest entry at index 0.
  int        mocc [2];
  step_t     steps [NSTEPS];
  integer    seed;
  int        errors;
  int        chk_errors;
  bit        idle_ok;

  instr_queue #(
    .DEPTH   (DEPTH),
    .WR_LANES(WR_LANES),
    .RD_LANES(RD_LANES)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .wr_valid    (wr_valid),
    .wr_thread   (wr_thread),
    .wr_mask     (wr_mask),
    .wr_data     (wr_data),
    .rd_thread   (rd_thread),
    .rd_take     (rd_take),
    .flush       (flush),
    .flush_thread(flush_thread),
    .wr_stall    (wr_stall),
    .rd_avail    (rd_avail),
    .rd_data     (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic step_t make_step(input logic wv, input logic wt,
                                      input logic [WR_LANES-1:0] wm, input logic rt,
                                      input logic [RD_LANES-1:0] tk, input logic fl,
                                      input logic ft);
    make_step = {wv, wt, wm, rt, tk, fl, ft};
  endfunction

  // wv wt mask rt take fl ft
  task automatic load_table();
    steps[0]  = make_step(0, 0, 4'b0000, 0, 4'b0000, 0, 0); // idle after reset.
    steps[1]  = make_step(1, 0, 4'b1111, 0, 4'b0000, 0, 0);
    steps[2]  = make_step(1, 0, 4'b0111, 0, 4'b0000, 0, 0);
    steps[3]  = make_step(0, 0, 4'b0000, 0, 4'b0011, 0, 0);
    steps[4]  = make_step(1, 0, 4'b1111, 0, 4'b1111, 0, 0); // write and pop together.
    steps[5]  = make_step(1, 0, 4'b1111, 0, 4'b1111, 0, 0);
    steps[6]  = make_step(1, 0, 4'b1111, 0, 4'b1111, 0, 0); // tail wraps here.
    steps[7]  = make_step(1, 0, 4'b1111, 0, 4'b1111, 0, 0);
    steps[8]  = make_step(0, 0, 4'b0000, 0, 4'b1111, 0, 0);
    steps[9]  = make_step(0, 0, 4'b0000, 0, 4'b1111, 0, 0); // take wider than avail.
    steps[10] = make_step(1, 0, 4'b1011, 0, 4'b0000, 0, 0); // only two leading ones.
    steps[11] = make_step(1, 0, 4'b0110, 0, 4'b0000, 0, 0); // no leading ones.
    steps[12] = make_step(1, 1, 4'b1111, 0, 4'b0000, 0, 0); // fill thread 1.
    steps[13] = make_step(1, 1, 4'b1111, 0, 4'b0000, 0, 0);
    steps[14] = make_step(1, 1, 4'b1111, 1, 4'b0000, 0, 0);
    steps[15] = make_step(1, 1, 4'b1111, 1, 4'b0000, 0, 0);
    steps[16] = make_step(1, 1, 4'b1111, 1, 4'b0000, 0, 0); // stalled so nothing is stored.
    steps[17] = make_step(1, 1, 4'b0011, 1, 4'b0000, 0, 0);
    steps[18] = make_step(0, 1, 4'b0000, 1, 4'b0001, 0, 0);
    steps[19] = make_step(1, 0, 4'b1111, 1, 4'b0001, 0, 0);
    steps[20] = make_step(0, 1, 4'b0000, 1, 4'b0011, 0, 0);
    steps[21] = make_step(1, 1, 4'b1111, 1, 4'b0000, 0, 0);
    steps[22] = make_step(0, 1, 4'b0000, 1, 4'b1111, 1, 1); // flush beats pop.
    steps[23] = make_step(1, 1, 4'b1111, 1, 4'b0000, 0, 0);
    steps[24] = make_step(1, 1, 4'b1111, 1, 4'b0011, 1, 1); // flush beats write and pop.
    steps[25] = make_step(0, 1, 4'b0000, 1, 4'b0000, 0, 0);
    steps[26] = make_step(0, 0, 4'b0000, 0, 4'b0000, 0, 0);
    steps[27] = make_step(1, 1, 4'b0111, 0, 4'b0000, 1, 0); // flush the other thread.
    steps[28] = make_step(0, 0, 4'b0000, 1, 4'b0000, 0, 0);
    steps[29] = make_step(0, 0, 4'b0000, 0, 4'b0000, 0, 0);
    steps[30] = make_step(0, 0, 4'b0000, 1, 4'b1111, 0, 0);
    steps[31] = make_step(0, 0, 4'b0000, 1, 4'b0000, 0, 0);
  endtask

  function automatic int prefix_len(input logic [31:0] m, input int width);
    int n;
    n = 0;
    while (n < width && m[n]) n++;
    return n;
  endfunction

  task automatic compare(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t: %s actual %0h expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic drive_step(input step_t s);
    wr_valid     = s.wr_valid;
    wr_thread    = s.wr_thread;
    wr_mask      = s.wr_mask;
    rd_thread    = s.rd_thread;
    rd_take      = s.rd_take;
    flush        = s.flush;
    flush_thread = s.flush_thread;
    for (int w = 0; w < WR_LANES; w++) begin
      wr_data[w].instr = $random(seed);
      wr_data[w].other = 8'($random(seed));
    end
  endtask

  task automatic check_outputs();
    int        t;
    logic      exp_av;
    iq_entry_t exp_data;
    t = rd_thread;
    compare("wr_stall", wr_stall, mocc[wr_thread] > DEPTH - WR_LANES);
    for (int r = 0; r < RD_LANES; r++) begin
      exp_av   = mocc[t] > r;
      exp_data = exp_av ? mq[t][r] : '0;
      compare($sformatf("rd_avail[%0d]", r), rd_avail[r], exp_av);
      compare($sformatf("rd_data[%0d]", r), rd_data[r], exp_data);
    end
  endtask

  // Advances the model across the coming clock edge.
  task automatic model_update();
    int wt;
    int rt;
    int wcnt;
    int pops;
    bit acc;
    wt   = wr_thread;
    rt   = rd_thread;
    acc  = wr_valid && !(mocc[wt] > DEPTH - WR_LANES);
    wcnt = prefix_len(32'(wr_mask), WR_LANES);
    pops = prefix_len(32'(rd_take), RD_LANES);
    if (pops > mocc[rt]) pops = mocc[rt];
    for (int i = 0; i < mocc[rt] - pops; i++) begin
      mq[rt][i] = mq[rt][i + pops];
    end
    mocc[rt] -= pops;
    if (acc) begin
      for (int w = 0; w < wcnt; w++) begin
        mq[wt][mocc[wt] + w] = wr_data[w];
      end
      mocc[wt] += wcnt;
    end
    if (flush) mocc[flush_thread] = 0;
  endtask

  task automatic wait_idle(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < IDLE_WAIT && !ok; n++) begin
      @(posedge clk);
      #1;
      if (wr_stall === 1'b0 && rd_avail === '0) ok = 1'b1;
    end
  endtask

  initial begin
    seed         = 32'hc0ea12f8;
    errors       = 0;
    rst          = 1'b1;
    wr_valid     = 1'b0;
    wr_thread    = 1'b0;
    wr_mask      = '0;
    wr_data      = '0;
    rd_thread    = 1'b0;
    rd_take      = '0;
    flush        = 1'b0;
    flush_thread = 1'b0;
    mocc[0]      = 0;
    mocc[1]      = 0;
    load_table();
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    wait_idle(idle_ok);
    if (!idle_ok) begin
      errors++;
      $display("timeout: queue did not settle to idle within %0d cycles of reset", IDLE_WAIT);
    end else begin
      for (int i = 0; i < NSTEPS; i++) begin
        @(posedge clk);
        #1;
        drive_step(steps[i]);
        #2; // outputs are settled well before the next edge.
        check_outputs();
        model_update();
      end
    end
    chk_errors = dut0.ctrl0.chk0.fail_cnt;
    $display("errors: %0d value checks, %0d assertions", errors, chk_errors);
    if (errors == 0 && chk_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : instr_queue_tb

`default_nettype wire

/* filelist.f */
src/iq_geom_pkg.sv
src/iq_entry_pkg.sv
src/iq_ctrl.sv
src/iq_store.sv
src/iq_read_port.sv
src/instr_queue.sv
bench/iq_chk.sv
bench/instr_queue_tb.sv
